// ==== files.f ====
+incdir+testbench
rtl/retire_trace_pkg.sv
rtl/trace_q_if.sv
rtl/rvc_expand.sv
rtl/trace_record_builder.sv
rtl/trace_fifo.sv
rtl/trace_wb_port.sv
rtl/retire_trace_top.sv
testbench/tb_retire_trace.sv

// ==== rtl/retire_trace_pkg.sv ====
// ----------------------------------------
// Retirement trace types and register map
// Record layout, register tags, immediate
// formats and Wishbone word offsets
// ----------------------------------------
package retire_trace_pkg;

  // Top bit set marks the FP register file, low five bits are the index
  typedef logic [5:0] reg_tag_t;

  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_e;

  // One retired instruction
  typedef struct packed {
    logic [31:0] cycle;
    logic [31:0] pc;
    logic [31:0] insn;
    logic        compressed;
    logic        unsupported;
    reg_tag_t    rd;
    reg_tag_t    rs1;
    reg_tag_t    rs2;
    logic [31:0] rd_value;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] imm;
  } trace_rec_t;

  // Word offsets on the Wishbone port
  localparam logic [3:0] REG_STATUS  = 4'd0;
  localparam logic [3:0] REG_CYCLE   = 4'd1;
  localparam logic [3:0] REG_PC      = 4'd2;
  localparam logic [3:0] REG_INSN    = 4'd3;
  localparam logic [3:0] REG_TAGS    = 4'd4;
  localparam logic [3:0] REG_RD_VAL  = 4'd5;
  localparam logic [3:0] REG_RS1_VAL = 4'd6;
  localparam logic [3:0] REG_RS2_VAL = 4'd7;
  localparam logic [3:0] REG_IMM     = 4'd8;
  localparam logic [3:0] REG_POP     = 4'd9;

endpackage

// ==== rtl/retire_trace_top.sv ====
// ----------------------------------------
// Retirement trace capture unit
// RVFI in, record FIFO, Wishbone readout
// ----------------------------------------
module retire_trace_top #(
  parameter int DEPTH = 8
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        valid_i,
  input  logic [31:0] insn_i,
  input  logic [31:0] pc_i,
  input  logic [4:0]  rd_addr_i,
  input  logic [31:0] rd_wdata_i,
  input  logic        frd_wvalid_i,
  input  logic [4:0]  frd_addr_i,
  input  logic [4:0]  rs1_addr_i,
  input  logic [4:0]  rs2_addr_i,
  input  logic [31:0] rs1_rdata_i,
  input  logic [31:0] rs2_rdata_i,
  input  logic        frs1_rvalid_i,
  input  logic        frs2_rvalid_i,
  input  logic [4:0]  frs1_addr_i,
  input  logic [4:0]  frs2_addr_i,
  input  logic [31:0] frs1_rdata_i,
  input  logic [31:0] frs2_rdata_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [3:0]  adr_i,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack_o
);

  import retire_trace_pkg::*;

  logic       rec_valid;
  trace_rec_t rec;

  trace_q_if q_if ();

  trace_record_builder u_builder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (valid_i),
    .pc_i         (pc_i),
    .insn_i       (insn_i),
    .rd_addr_i    (rd_addr_i),
    .rd_wdata_i   (rd_wdata_i),
    .frd_wvalid_i (frd_wvalid_i),
    .frd_addr_i   (frd_addr_i),
    .rs1_addr_i   (rs1_addr_i),
    .rs2_addr_i   (rs2_addr_i),
    .rs1_rdata_i  (rs1_rdata_i),
    .rs2_rdata_i  (rs2_rdata_i),
    .frs1_rvalid_i(frs1_rvalid_i),
    .frs2_rvalid_i(frs2_rvalid_i),
    .frs1_addr_i  (frs1_addr_i),
    .frs2_addr_i  (frs2_addr_i),
    .frs1_rdata_i (frs1_rdata_i),
    .frs2_rdata_i (frs2_rdata_i),
    .rec_valid_o  (rec_valid),
    .rec_o        (rec)
  );

  trace_fifo #(
    .DEPTH(DEPTH)
  ) u_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wr_i   (rec_valid),
    .wdata_i(rec),
    .q      (q_if.producer)
  );

  trace_wb_port u_wb_port (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .cyc_i (cyc_i),
    .stb_i (stb_i),
    .we_i  (we_i),
    .adr_i (adr_i),
    .dat_i (dat_i),
    .dat_o (dat_o),
    .ack_o (ack_o),
    .q     (q_if.consumer)
  );

endmodule

// ==== rtl/rvc_expand.sv ====
// ----------------------------------------
// RV32C expander for a small subset
// Rewrites supported compressed forms into
// their 32-bit base encodings
// ----------------------------------------
module rvc_expand (
  input  logic [31:0] insn_i,
  output logic [31:0] insn_o,
  output logic        compressed_o,
  output logic        unsupported_o
);

  logic [15:0] c;
  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;
  logic [4:0]  rd_p;
  logic [4:0]  rs1_p;

  assign c        = insn_i[15:0];
  assign rd_full  = c[11:7];
  assign rs2_full = c[6:2];
  // Compact register fields address x8..x15
  assign rd_p     = {2'b01, c[4:2]};
  assign rs1_p    = {2'b01, c[9:7]};

  assign compressed_o = (insn_i[1:0] != 2'b11);

  always_comb begin
    insn_o        = {16'b0, c};
    unsupported_o = compressed_o;
    if (!compressed_o) begin
      insn_o = insn_i;
    end else begin
      unique case ({c[1:0], c[15:13]})
        5'b00_010: begin  // C.LW
          insn_o = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, 3'b010, rd_p, 7'b0000011};
          unsupported_o = 1'b0;
        end
        5'b00_110: begin  // C.SW
          insn_o = {5'b0, c[5], c[12], rd_p, rs1_p, 3'b010, c[11:10], c[6], 2'b00,
                    7'b0100011};
          unsupported_o = 1'b0;
        end
        5'b01_000: begin  // C.ADDI
          insn_o = {{7{c[12]}}, c[6:2], rd_full, 3'b000, rd_full, 7'b0010011};
          unsupported_o = 1'b0;
        end
        5'b01_010: begin  // C.LI
          insn_o = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd_full, 7'b0010011};
          unsupported_o = 1'b0;
        end
        5'b01_011: begin
          // rd of x2 is C.ADDI16SP, which stays unsupported
          if (rd_full != 5'd2) begin
            insn_o = {{15{c[12]}}, c[6:2], rd_full, 7'b0110111};
            unsupported_o = 1'b0;
          end
        end
        5'b01_101: begin  // C.J becomes JAL x0
          insn_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], c[12],
                    {8{c[12]}}, 5'd0, 7'b1101111};
          unsupported_o = 1'b0;
        end
        5'b10_100: begin
          // C.MV and C.ADD, a zero rs2 means a jump or ebreak
          if (rs2_full != 5'd0) begin
            insn_o = {7'b0, rs2_full, c[12] ? rd_full : 5'd0, 3'b000, rd_full, 7'b0110011};
            unsupported_o = 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/trace_fifo.sv ====
// ----------------------------------------
// Trace record FIFO
// Circular queue that drops when full and
// keeps a sticky overflow flag
// ----------------------------------------
module trace_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         wr_i,
  input  retire_trace_pkg::trace_rec_t wdata_i,
  trace_q_if.producer                  q
);

  import retire_trace_pkg::*;

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

  trace_rec_t    mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          ovf_q;
  logic          empty;
  logic          full;
  logic          do_pop;
  logic          do_push;

  assign empty   = (count_q == '0);
  assign full    = (count_q == FULL_CNT);
  assign do_pop  = q.pop && !empty;
  // A pop in the same cycle frees a slot for the arriving record
  assign do_push = wr_i && (!full || do_pop);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ovf_q    <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      // A drop in the clearing cycle is still reported
      if (wr_i && !do_push) begin
        ovf_q <= 1'b1;
      end else if (q.clr_ovf) begin
        ovf_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr_q] <= wdata_i;
  end

  assign q.head     = mem[rd_ptr_q];
  assign q.empty    = empty;
  assign q.count    = 16'(count_q);
  assign q.overflow = ovf_q;

endmodule

// ==== rtl/trace_q_if.sv ====
// ----------------------------------------
// Queue link between FIFO and bus port
// ----------------------------------------
interface trace_q_if;

  import retire_trace_pkg::*;

  trace_rec_t  head;
  logic        empty;
  logic [15:0] count;
  logic        overflow;
  logic        pop;
  logic        clr_ovf;

  modport producer (output head, empty, count, overflow, input pop, clr_ovf);

  modport consumer (input head, empty, count, overflow, output pop, clr_ovf);

endinterface

// ==== rtl/trace_record_builder.sv ====
// ----------------------------------------
// Trace record builder
// Tags registers, extracts the immediate,
// stamps the cycle and registers a record
// ----------------------------------------
module trace_record_builder (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         valid_i,
  input  logic [31:0]                  pc_i,
  input  logic [31:0]                  insn_i,
  input  logic [4:0]                   rd_addr_i,
  input  logic [31:0]                  rd_wdata_i,
  input  logic                         frd_wvalid_i,
  input  logic [4:0]                   frd_addr_i,
  input  logic [4:0]                   rs1_addr_i,
  input  logic [4:0]                   rs2_addr_i,
  input  logic [31:0]                  rs1_rdata_i,
  input  logic [31:0]                  rs2_rdata_i,
  input  logic                         frs1_rvalid_i,
  input  logic                         frs2_rvalid_i,
  input  logic [4:0]                   frs1_addr_i,
  input  logic [4:0]                   frs2_addr_i,
  input  logic [31:0]                  frs1_rdata_i,
  input  logic [31:0]                  frs2_rdata_i,
  output logic                         rec_valid_o,
  output retire_trace_pkg::trace_rec_t rec_o
);

  import retire_trace_pkg::*;

  logic [31:0] insn_exp;
  logic        compressed;
  logic        unsupported;
  reg_tag_t    rd_tag;
  reg_tag_t    rs1_tag;
  reg_tag_t    rs2_tag;
  logic [31:0] rs1_value;
  logic [31:0] rs2_value;
  imm_fmt_e    imm_fmt;
  logic [31:0] imm;
  logic [31:0] cycle_q;
  logic        rec_valid_q;
  trace_rec_t  rec_q;

  rvc_expand u_rvc_expand (
    .insn_i       (insn_i),
    .insn_o       (insn_exp),
    .compressed_o (compressed),
    .unsupported_o(unsupported)
  );

  // FP flag picks the FP file and sets the tag top bit
  assign rd_tag    = frd_wvalid_i ? {1'b1, frd_addr_i} : {1'b0, rd_addr_i};
  assign rs1_tag   = frs1_rvalid_i ? {1'b1, frs1_addr_i} : {1'b0, rs1_addr_i};
  assign rs2_tag   = frs2_rvalid_i ? {1'b1, frs2_addr_i} : {1'b0, rs2_addr_i};
  assign rs1_value = frs1_rvalid_i ? frs1_rdata_i : rs1_rdata_i;
  assign rs2_value = frs2_rvalid_i ? frs2_rdata_i : rs2_rdata_i;

  always_comb begin
    unique case (insn_exp[6:0])
      7'b0010011, 7'b0000011, 7'b1100111: imm_fmt = IMM_I;
      7'b0100011:                         imm_fmt = IMM_S;
      7'b1100011:                         imm_fmt = IMM_B;
      7'b0110111, 7'b0010111:             imm_fmt = IMM_U;
      7'b1101111:                         imm_fmt = IMM_J;
      default:                            imm_fmt = IMM_NONE;
    endcase
  end

  always_comb begin
    unique case (imm_fmt)
      IMM_I:   imm = {{20{insn_exp[31]}}, insn_exp[31:20]};
      IMM_S:   imm = {{20{insn_exp[31]}}, insn_exp[31:25], insn_exp[11:7]};
      IMM_B:   imm = {{19{insn_exp[31]}}, insn_exp[31], insn_exp[7], insn_exp[30:25],
                      insn_exp[11:8], 1'b0};
      IMM_U:   imm = {insn_exp[31:12], 12'b0};
      IMM_J:   imm = {{12{insn_exp[31]}}, insn_exp[19:12], insn_exp[20], insn_exp[30:21],
                      1'b0};
      default: imm = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q     <= '0;
      rec_valid_q <= 1'b0;
    end else begin
      cycle_q     <= cycle_q + 32'd1;
      rec_valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rec_q <= '{cycle: cycle_q, pc: pc_i, insn: insn_exp, compressed: compressed,
                 unsupported: unsupported, rd: rd_tag, rs1: rs1_tag, rs2: rs2_tag,
                 rd_value: rd_wdata_i, rs1_value: rs1_value, rs2_value: rs2_value,
                 imm: imm};
    end
  end

  assign rec_valid_o = rec_valid_q;
  assign rec_o       = rec_q;

endmodule

// ==== rtl/trace_wb_port.sv ====
// ----------------------------------------
// Wishbone classic slave for the trace FIFO
// Maps head record and status to words and
// pops or clears overflow on writes
// ----------------------------------------
module trace_wb_port (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [3:0]  adr_i,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  trace_q_if.consumer q
);

  import retire_trace_pkg::*;

  logic        req;
  logic [31:0] rdata;
  logic [31:0] dat_q;
  logic        ack_q;
  logic        pop_q;
  logic        clr_q;

  // No new request is taken while ack is high
  assign req = cyc_i && stb_i && !ack_q;

  always_comb begin
    rdata = '0;
    if (adr_i == REG_STATUS) begin
      rdata = {14'b0, q.empty, q.overflow, q.count};
    end else if (!q.empty) begin
      unique case (adr_i)
        REG_CYCLE:   rdata = q.head.cycle;
        REG_PC:      rdata = q.head.pc;
        REG_INSN:    rdata = q.head.insn;
        REG_TAGS:    rdata = {6'b0, q.head.unsupported, q.head.compressed, 2'b0, q.head.rs2,
                              2'b0, q.head.rs1, 2'b0, q.head.rd};
        REG_RD_VAL:  rdata = q.head.rd_value;
        REG_RS1_VAL: rdata = q.head.rs1_value;
        REG_RS2_VAL: rdata = q.head.rs2_value;
        REG_IMM:     rdata = q.head.imm;
        default:     rdata = '0;
      endcase
    end
  end

  // Any write to the status word clears overflow
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      pop_q <= 1'b0;
      clr_q <= 1'b0;
    end else begin
      ack_q <= req;
      pop_q <= req && we_i && (adr_i == REG_POP) && !q.empty;
      clr_q <= req && we_i && (adr_i == REG_STATUS);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req && !we_i) dat_q <= rdata;
  end

  assign dat_o     = dat_q;
  assign ack_o     = ack_q;
  assign q.pop     = pop_q;
  assign q.clr_ovf = clr_q;

endmodule

// ==== testbench/tb_trace_model.svh ====
// ----------------------------------------
// Reference model for the trace testbench
// Random source, RV32C expander, record
// builder and compare tasks
// ----------------------------------------
`ifndef TB_TRACE_MODEL_SVH
`define TB_TRACE_MODEL_SVH

// One retirement as driven on the RVFI port
typedef struct packed {
  logic [31:0] pc, insn, rd_wdata;
  logic [31:0] rs1_rdata, rs2_rdata, frs1_rdata, frs2_rdata;
  logic [4:0]  rd_addr, frd_addr, rs1_addr, rs2_addr, frs1_addr, frs2_addr;
  logic        frd_wvalid, frs1_rvalid, frs2_rvalid;
} retire_t;

logic [31:0] lfsr_q = 32'hfd94_9247;

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_q[0]};
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
  end
  return v;
endfunction

function automatic retire_t rand_retire(input logic [31:0] insn, input logic fp_mix);
  retire_t r;
  r.pc          = rand_bits(32) & 32'hffff_fffe;
  r.insn        = insn;
  r.rd_wdata    = rand_bits(32);
  r.rs1_rdata   = rand_bits(32);
  r.rs2_rdata   = rand_bits(32);
  r.frs1_rdata  = rand_bits(32);
  r.frs2_rdata  = rand_bits(32);
  r.rd_addr     = 5'(rand_bits(5));
  r.frd_addr    = 5'(rand_bits(5));
  r.rs1_addr    = 5'(rand_bits(5));
  r.rs2_addr    = 5'(rand_bits(5));
  r.frs1_addr   = 5'(rand_bits(5));
  r.frs2_addr   = 5'(rand_bits(5));
  r.frd_wvalid  = fp_mix && (rand_bits(1) != 0);
  r.frs1_rvalid = fp_mix && (rand_bits(1) != 0);
  r.frs2_rvalid = fp_mix && (rand_bits(1) != 0);
  return r;
endfunction

// Returns {unsupported, compressed, expanded instruction}
function automatic logic [33:0] ref_expand(input logic [31:0] raw);
  logic [15:0] c;
  logic [31:0] imm;
  logic [31:0] res;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rdp;
  logic [4:0]  rs1p;
  logic        unsup;
  c     = raw[15:0];
  rd    = c[11:7];
  rs2   = c[6:2];
  rdp   = 5'd8 + c[4:2];
  rs1p  = 5'd8 + c[9:7];
  res   = {16'h0, c};
  unsup = 1'b1;
  if (raw[1:0] == 2'b11) begin
    return {2'b00, raw};
  end
  // Uncompressed opcode and immediate per the RVC spec tables
  imm = {25'h0, c[5], c[12:10], c[6], 2'b00};
  case ({c[15:13], c[1:0]})
    5'b000_01: begin
      res   = {{7{c[12]}}, c[6:2], rd, 3'b000, rd, 7'h13};
      unsup = 1'b0;
    end
    5'b010_01: begin
      res   = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd, 7'h13};
      unsup = 1'b0;
    end
    5'b011_01: begin
      if (rd != 5'd2) begin
        imm   = {{14{c[12]}}, c[12], c[6:2], 12'h0};
        res   = {imm[31:12], rd, 7'h37};
        unsup = 1'b0;
      end
    end
    5'b101_01: begin
      imm   = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
      res   = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'h6f};
      unsup = 1'b0;
    end
    5'b010_00: begin
      res   = {imm[11:0], rs1p, 3'b010, rdp, 7'h03};
      unsup = 1'b0;
    end
    5'b110_00: begin
      res   = {imm[11:5], rdp, rs1p, 3'b010, imm[4:0], 7'h23};
      unsup = 1'b0;
    end
    5'b100_10: begin
      if (rs2 != 5'd0) begin
        res   = {7'h0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'h33};
        unsup = 1'b0;
      end
    end
    default: ;
  endcase
  return {unsup, 1'b1, res};
endfunction

function automatic trace_rec_t ref_build(input retire_t r, input logic [31:0] cyc);
  trace_rec_t  t;
  logic [33:0] e;
  logic [31:0] x;
  e             = ref_expand(r.insn);
  x             = e[31:0];
  t.cycle       = cyc;
  t.pc          = r.pc;
  t.insn        = x;
  t.compressed  = e[32];
  t.unsupported = e[33];
  t.rd          = r.frd_wvalid ? {1'b1, r.frd_addr} : {1'b0, r.rd_addr};
  t.rs1         = r.frs1_rvalid ? {1'b1, r.frs1_addr} : {1'b0, r.rs1_addr};
  t.rs2         = r.frs2_rvalid ? {1'b1, r.frs2_addr} : {1'b0, r.rs2_addr};
  t.rd_value    = r.rd_wdata;
  t.rs1_value   = r.frs1_rvalid ? r.frs1_rdata : r.rs1_rdata;
  t.rs2_value   = r.frs2_rvalid ? r.frs2_rdata : r.rs2_rdata;
  case (x[6:0])
    7'h13, 7'h03, 7'h67: t.imm = {{20{x[31]}}, x[31:20]};
    7'h23:               t.imm = {{20{x[31]}}, x[31:25], x[11:7]};
    7'h63:               t.imm = {{20{x[31]}}, x[7], x[30:25], x[11:8], 1'b0};
    7'h37, 7'h17:        t.imm = {x[31:12], 12'h0};
    7'h6f:               t.imm = {{12{x[31]}}, x[19:12], x[20], x[30:21], 1'b0};
    default:             t.imm = '0;
  endcase
  return t;
endfunction

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (act !== exp) begin
    $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
    errors++;
  end
endtask

task automatic check_rec(input trace_rec_t exp, input trace_rec_t act);
  check_word("cycle", exp.cycle, act.cycle);
  check_word("pc", exp.pc, act.pc);
  check_word("insn", exp.insn, act.insn);
  check_word("compressed", 32'(exp.compressed), 32'(act.compressed));
  check_word("unsupported", 32'(exp.unsupported), 32'(act.unsupported));
  check_word("rd", 32'(exp.rd), 32'(act.rd));
  check_word("rs1", 32'(exp.rs1), 32'(act.rs1));
  check_word("rs2", 32'(exp.rs2), 32'(act.rs2));
  check_word("rd_value", exp.rd_value, act.rd_value);
  check_word("rs1_value", exp.rs1_value, act.rs1_value);
  check_word("rs2_value", exp.rs2_value, act.rs2_value);
  check_word("imm", exp.imm, act.imm);
endtask

`endif

// ==== testbench/tb_retire_trace.sv ====
// ----------------------------------------
// Testbench for the retirement trace unit
// Drives RVFI retirements and reads the
// records back over Wishbone
// ----------------------------------------
module tb_retire_trace;

  timeunit 1ns;
  timeprecision 100ps;

  import retire_trace_pkg::*;

  localparam int DEPTH       = 8;
  localparam int ACK_TIMEOUT = 20;
  // Opcodes of OP-IMM, LOAD, JALR, STORE, BRANCH, LUI, AUIPC, JAL, OP
  localparam logic [62:0] OPS = {7'h13, 7'h03, 7'h67, 7'h23, 7'h63, 7'h37, 7'h17, 7'h6f, 7'h33};

  logic        clk_i = 1'b0;
  logic        rst_ni = 1'b0;
  logic        valid_i;
  logic [31:0] insn_i;
  logic [31:0] pc_i;
  logic [4:0]  rd_addr_i;
  logic [31:0] rd_wdata_i;
  logic        frd_wvalid_i;
  logic [4:0]  frd_addr_i;
  logic [4:0]  rs1_addr_i;
  logic [4:0]  rs2_addr_i;
  logic [31:0] rs1_rdata_i;
  logic [31:0] rs2_rdata_i;
  logic        frs1_rvalid_i;
  logic        frs2_rvalid_i;
  logic [4:0]  frs1_addr_i;
  logic [4:0]  frs2_addr_i;
  logic [31:0] frs1_rdata_i;
  logic [31:0] frs2_rdata_i;
  logic        cyc_i;
  logic        stb_i;
  logic        we_i;
  logic [3:0]  adr_i;
  logic [31:0] dat_i;
  logic [31:0] dat_o;
  logic        ack_o;

  int         errors = 0;
  int         tests = 0;
  int         test_err0;
  int         tb_cycle = 0;
  trace_rec_t exp_q[$];
  trace_rec_t got_q[$];
  trace_rec_t got_rec;

  `include "tb_trace_model.svh"

  retire_trace_top #(
    .DEPTH(DEPTH)
  ) uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (valid_i),
    .insn_i       (insn_i),
    .pc_i         (pc_i),
    .rd_addr_i    (rd_addr_i),
    .rd_wdata_i   (rd_wdata_i),
    .frd_wvalid_i (frd_wvalid_i),
    .frd_addr_i   (frd_addr_i),
    .rs1_addr_i   (rs1_addr_i),
    .rs2_addr_i   (rs2_addr_i),
    .rs1_rdata_i  (rs1_rdata_i),
    .rs2_rdata_i  (rs2_rdata_i),
    .frs1_rvalid_i(frs1_rvalid_i),
    .frs2_rvalid_i(frs2_rvalid_i),
    .frs1_addr_i  (frs1_addr_i),
    .frs2_addr_i  (frs2_addr_i),
    .frs1_rdata_i (frs1_rdata_i),
    .frs2_rdata_i (frs2_rdata_i),
    .cyc_i        (cyc_i),
    .stb_i        (stb_i),
    .we_i         (we_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .dat_o        (dat_o),
    .ack_o        (ack_o)
  );

  always #2 clk_i = ~clk_i;

  // Cycle count from reset release for the expected stamp
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tb_cycle <= 0;
    end else begin
      tb_cycle <= tb_cycle + 1;
    end
  end

  // Records read back are matched against the expected queue in order
  always @(posedge clk_i) begin
    while (got_q.size() > 0) begin
      got_rec = got_q.pop_front();
      if (exp_q.size() == 0) begin
        $display("%0t: a record was read back with none expected", $time);
        errors++;
      end else begin
        check_rec(exp_q.pop_front(), got_rec);
      end
    end
  end

  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display("Something failed");
    $finish;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic drive_rvfi(input retire_t r);
    pc_i          = r.pc;
    insn_i        = r.insn;
    rd_addr_i     = r.rd_addr;
    rd_wdata_i    = r.rd_wdata;
    frd_wvalid_i  = r.frd_wvalid;
    frd_addr_i    = r.frd_addr;
    rs1_addr_i    = r.rs1_addr;
    rs2_addr_i    = r.rs2_addr;
    rs1_rdata_i   = r.rs1_rdata;
    rs2_rdata_i   = r.rs2_rdata;
    frs1_rvalid_i = r.frs1_rvalid;
    frs2_rvalid_i = r.frs2_rvalid;
    frs1_addr_i   = r.frs1_addr;
    frs2_addr_i   = r.frs2_addr;
    frs1_rdata_i  = r.frs1_rdata;
    frs2_rdata_i  = r.frs2_rdata;
  endtask

  task automatic retire(input retire_t r, input logic keep);
    drive_rvfi(r);
    valid_i = 1'b1;
    if (keep) exp_q.push_back(ref_build(r, 32'(tb_cycle)));
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
  endtask

  // One Wishbone classic transfer followed by an idle cycle
  task automatic bus_xfer(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    int n;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr;
    dat_i = wdata;
    n     = 0;
    do begin
      @(posedge clk_i);
      #1;
      n++;
    end while (!ack_o && n < ACK_TIMEOUT);
    rdata = dat_o;
    if (!ack_o) begin
      abort_run($sformatf("no Wishbone ack for address %0d", adr));
    end else begin
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      idle(1);
    end
  endtask

  task automatic bus_read(input logic [3:0] adr, output logic [31:0] rdata);
    bus_xfer(1'b0, adr, 32'h0, rdata);
  endtask

  task automatic bus_write(input logic [3:0] adr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_xfer(1'b1, adr, wdata, unused);
  endtask

  function automatic logic [31:0] status_word(input int count, input logic ovf,
                                              input logic empty);
    return {14'b0, empty, ovf, 16'(count)};
  endfunction

  task automatic read_head(output trace_rec_t rec);
    logic [31:0] w;
    bus_read(REG_CYCLE, w);
    rec.cycle = w;
    bus_read(REG_PC, w);
    rec.pc = w;
    bus_read(REG_INSN, w);
    rec.insn = w;
    bus_read(REG_TAGS, w);
    rec.rd          = w[5:0];
    rec.rs1         = w[13:8];
    rec.rs2         = w[21:16];
    rec.compressed  = w[24];
    rec.unsupported = w[25];
    bus_read(REG_RD_VAL, w);
    rec.rd_value = w;
    bus_read(REG_RS1_VAL, w);
    rec.rs1_value = w;
    bus_read(REG_RS2_VAL, w);
    rec.rs2_value = w;
    bus_read(REG_IMM, w);
    rec.imm = w;
  endtask

  // Read and pop the head until status reports empty
  task automatic drain_all();
    logic [31:0] st;
    trace_rec_t  rec;
    int          guard;
    idle(2);
    guard = 0;
    bus_read(REG_STATUS, st);
    while (!st[17] && guard < 4 * DEPTH) begin
      read_head(rec);
      got_q.push_back(rec);
      bus_write(REG_POP, 32'h0);
      bus_read(REG_STATUS, st);
      guard++;
    end
    if (!st[17]) begin
      $display("%0t: FIFO still not empty after %0d pops", $time, guard);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    idle(1);
    if (exp_q.size() != 0) begin
      $display("%0t: %s left %0d expected records unread", $time, name, exp_q.size());
      errors++;
      exp_q.delete();
    end
    tests++;
    if (errors == test_err0) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s with %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  function automatic logic [15:0] rvc_sample(input int k);
    logic [31:0] v;
    logic [4:0]  rd;
    v  = rand_bits(16);
    rd = v[11:7];
    if (rd == 5'd0 || rd == 5'd2) rd = 5'd9;
    case (k)
      0:       return {3'b000, v[12:2], 2'b01};
      1:       return {3'b010, v[12:2], 2'b01};
      2:       return {3'b011, v[12], rd, v[6:2], 2'b01};
      3:       return {4'b1000, v[11:7], v[6:3], 1'b1, 2'b10};
      4:       return {4'b1001, v[11:7], v[6:3], 1'b1, 2'b10};
      5:       return {3'b010, v[12:2], 2'b00};
      6:       return {3'b110, v[12:2], 2'b00};
      7:       return {3'b101, v[12:2], 2'b01};
      // C.JR lies outside the supported subset
      default: return {4'b1000, v[11:8], 1'b1, 5'd0, 2'b10};
    endcase
  endfunction

  initial begin
    logic [31:0] w;
    logic [31:0] hi;
    retire_t     r;
    valid_i   = 1'b0;
    drive_rvfi('0);
    cyc_i     = 1'b0;
    stb_i     = 1'b0;
    we_i      = 1'b0;
    adr_i     = 4'h0;
    dat_i     = 32'h0;
    test_err0 = 0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    idle(2);

    for (int i = 0; i < 9; i++) begin
      w = rand_bits(25);
      retire(rand_retire({w[24:0], OPS[i*7 +: 7]}, 1'b0), 1'b1);
      if (i % 4 == 3) drain_all();
    end
    drain_all();
    end_test("integer retirements of every immediate format");

    for (int i = 0; i < 12; i++) begin
      retire(rand_retire(rand_bits(32) | 32'h3, 1'b1), 1'b1);
      if (i % 4 == 3) drain_all();
    end
    end_test("FP register selection");

    for (int i = 0; i < 9; i++) begin
      hi = rand_bits(16);
      retire(rand_retire({hi[15:0], rvc_sample(i)}, 1'b0), 1'b1);
      if (i % 4 == 3) drain_all();
    end
    drain_all();
    end_test("compressed expansion");

    bus_read(REG_STATUS, w);
    check_word("status", status_word(0, 1'b0, 1'b1), w);
    for (int a = REG_CYCLE; a <= REG_IMM; a++) begin
      bus_read(4'(a), w);
      check_word($sformatf("word %0d", a), 32'h0, w);
    end
    for (int i = 0; i < 5; i++) retire(rand_retire(rand_bits(32), 1'b1), 1'b1);
    idle(2);
    bus_read(REG_STATUS, w);
    check_word("status", status_word(5, 1'b0, 1'b0), w);
    drain_all();
    end_test("empty FIFO and count");

    for (int i = 0; i < DEPTH + 3; i++) begin
      r = rand_retire(rand_bits(32), 1'b1);
      retire(r, i < DEPTH);
    end
    idle(2);
    bus_read(REG_STATUS, w);
    check_word("status", status_word(DEPTH, 1'b1, 1'b0), w);
    bus_write(REG_STATUS, 32'h0);
    bus_read(REG_STATUS, w);
    check_word("status", status_word(DEPTH, 1'b0, 1'b0), w);
    drain_all();
    end_test("overflow drop and clear");

    for (int i = 0; i < 6; i++) retire(rand_retire(rand_bits(32), 1'b1), 1'b1);
    drain_all();
    bus_read(REG_STATUS, w);
    check_word("status", status_word(0, 1'b0, 1'b1), w);
    end_test("drain in order");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
